// ==== src.f ====
design/valu_ops_pkg.sv
design/valu_pkg.sv
design/beat_counter.sv
design/valu_decode.sv
design/lane_alu.sv
design/red_fsm.sv
design/red_accum.sv
design/resp_stage.sv
design/valu_top.sv
test/valu_assert.sv
test/valu_tb.sv

// ==== test/valu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module valu_tb;
    import valu_pkg::*;
    import valu_ops_pkg::*;

    localparam int N_CYCLES = 5 + 24 + 4 + 16 + 12 + 16 + 40 + 4; // reset, tests, drain

    typedef struct packed {
        vec_t  data;
        addr_t addr;
        be_t   be;
        logic  start;
        logic  last;
    } resp_t;

    logic       clk         = 1'b0;
    logic       rst         = 1'b1;
    logic       req_valid   = 1'b1; // beats offered during reset must be dropped
    logic [2:0] req_op_mnr  = '0;
    logic [5:0] req_func_id = '0;
    sew_t       req_sew     = '0;
    vec_t       req_data0   = '0;
    vec_t       req_data1   = '0;
    addr_t      req_addr    = '0;
    be_t        req_be      = '0;
    logic       req_start   = 1'b0;
    logic       req_end     = 1'b0;
    logic       resp_valid;
    logic       resp_start;
    logic       resp_end;
    vec_t       resp_data;
    addr_t      resp_addr;
    be_t        resp_be;

    integer seed      = 32'hbf0a_4f23;
    int     cyc       = 0;
    int     grp_beat  = 0;
    vec_t   red_acc   = '0;
    logic   red_on    = 1'b0;
    string  test_name = "";

    resp_t  exp_q [$];
    string  name_q [$];
    int     due_q [$];

    resp_t  want;            // head of the queue for the current response
    string  want_name = "";
    int     want_due  = 0;
    logic   want_avail = 1'b0;
    int     resp_cyc  = 0;

    valu_top u_dut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    task automatic fail_run(string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_value(string test, string what, vec_t expv, vec_t actv);
        fail_run($sformatf("FAILED %s %s expected %0h actual %0h", test, what, expv, actv));
    endtask

    function automatic vec_t rand_vec();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic vec_t elem_mask(sew_t sew);
        return (sew == 2'd3) ? '1 : (64'd1 << (8 << sew)) - 64'd1;
    endfunction

    function automatic logic [8:0] encode_op(alu_op_e op);
        case (op)
            ADD:     return {OPIVV, FUNCT6_VADD};
            SUB:     return {OPIVV, FUNCT6_VSUB};
            MINU:    return {OPIVV, FUNCT6_VMINU};
            MIN:     return {OPIVV, FUNCT6_VMIN};
            MAXU:    return {OPIVV, FUNCT6_VMAXU};
            MAX:     return {OPIVV, FUNCT6_VMAX};
            AND:     return {OPIVV, FUNCT6_VAND};
            OR:      return {OPIVV, FUNCT6_VOR};
            XOR:     return {OPIVV, FUNCT6_VXOR};
            VID:     return {OPMVV, FUNCT6_VID};
            REDSUM:  return {OPMVV, FUNCT6_VREDSUM};
            default: return {3'd7, 6'h3f}; // no such opcode
        endcase
    endfunction

    // element i of the result is d1[i] op d0[i]
    function automatic vec_t ref_alu(alu_op_e op, sew_t sew, vec_t d0, vec_t d1, int base);
        int     ew;
        vec_t   m;
        vec_t   a;
        vec_t   b;
        vec_t   r;
        vec_t   res;
        longint sa;
        longint sb;
        ew  = 8 << sew;
        m   = elem_mask(sew);
        res = '0;
        for (int i = 0; i < 64 / ew; i++) begin
            a  = (d1 >> (i * ew)) & m;
            b  = (d0 >> (i * ew)) & m;
            sa = $signed(a << (64 - ew)) >>> (64 - ew);
            sb = $signed(b << (64 - ew)) >>> (64 - ew);
            case (op)
                ADD:     r = a + b;
                SUB:     r = a - b;
                MINU:    r = (a < b) ? a : b;
                MIN:     r = (sa < sb) ? a : b;
                MAXU:    r = (a < b) ? b : a;
                MAX:     r = (sa < sb) ? b : a;
                AND:     r = a & b;
                OR:      r = a | b;
                XOR:     r = a ^ b;
                VID:     r = vec_t'(base + i);
                default: r = '0;
            endcase
            res |= (r & m) << (i * ew);
        end
        return res;
    endfunction

    task automatic send(alu_op_e op, sew_t sew, vec_t d0, vec_t d1, logic st, logic en);
        resp_t r;
        vec_t  m;
        vec_t  bsum;
        int    ew;
        logic  keep;
        ew   = 8 << sew;
        m    = elem_mask(sew);
        keep = (op != NONE) && (op != REDSUM);
        if (st)
            grp_beat = 0;
        r.addr  = $random(seed);
        r.be    = be_t'($random(seed));
        r.start = st;
        r.last  = en;
        r.data  = ref_alu(op, sew, d0, d1, grp_beat * (64 / ew));
        req_valid <= 1'b1;
        {req_op_mnr, req_func_id} <= encode_op(op);
        req_sew   <= sew;
        req_data0 <= d0;
        req_data1 <= d1;
        req_addr  <= r.addr;
        req_be    <= r.be;
        req_start <= st;
        req_end   <= en;
        if (op == REDSUM) begin
            bsum = '0;
            for (int i = 0; i < 64 / ew; i++)
                bsum += (d1 >> (i * ew)) & m;
            if (st)
                red_acc = d0 & m;   // seed is element 0 of data0
            if (st || red_on) begin
                red_acc += bsum;
                red_on   = !en;
                keep     = en;
                r.data   = red_acc & m;
            end
        end
        if (keep) begin
            exp_q.push_back(r);
            name_q.push_back(test_name);
            due_q.push_back(cyc + 4); // seen three edges after the DUT samples it
        end
        grp_beat++;
        @(posedge clk);
    endtask

    // load the expected head while the outputs are stable
    always @(negedge clk) begin
        resp_cyc = cyc;
        if (u_dut.u_assert.fail_cnt != 0) begin
            fail_run("a bound protocol assertion failed");
        end else if (!rst && resp_valid) begin
            want_avail = exp_q.size() != 0;
            if (want_avail) begin
                want      = exp_q.pop_front();
                want_name = name_q.pop_front();
                want_due  = due_q.pop_front();
            end
        end
    end

    known_ok: assert property (@(posedge clk) disable iff (rst) resp_valid |-> want_avail)
        else fail_run("a response appeared that no beat should have produced");
    cycle_ok: assert property (@(posedge clk) disable iff (rst)
        resp_valid && want_avail |-> want_due == resp_cyc)
        else report_value(want_name, "cycle", vec_t'(want_due), vec_t'(resp_cyc));
    data_ok: assert property (@(posedge clk) disable iff (rst)
        resp_valid && want_avail |-> resp_data == want.data)
        else report_value(want_name, "data", want.data, $sampled(resp_data));
    addr_ok: assert property (@(posedge clk) disable iff (rst)
        resp_valid && want_avail |-> resp_addr == want.addr)
        else report_value(want_name, "addr", vec_t'(want.addr), vec_t'($sampled(resp_addr)));
    be_ok: assert property (@(posedge clk) disable iff (rst)
        resp_valid && want_avail |-> resp_be == want.be)
        else report_value(want_name, "be", vec_t'(want.be), vec_t'($sampled(resp_be)));
    start_ok: assert property (@(posedge clk) disable iff (rst)
        resp_valid && want_avail |-> resp_start == want.start)
        else report_value(want_name, "start", vec_t'(want.start), vec_t'($sampled(resp_start)));
    end_ok: assert property (@(posedge clk) disable iff (rst)
        resp_valid && want_avail |-> resp_end == want.last)
        else report_value(want_name, "end", vec_t'(want.last), vec_t'($sampled(resp_end)));

    initial begin
        #((N_CYCLES + 20) * 40);
        fail_run("watchdog expired before the tests finished");
    end

    initial begin
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        test_name = "bitwise";
        for (int s = 0; s < 4; s++)
            for (int k = 0; k < 6; k++)
                send(alu_op_e'(AND + k % 3), sew_t'(s), rand_vec(), rand_vec(), 1'b1, 1'b1);

        test_name = "add_sub_wrap";
        send(ADD, 2'd0, 64'h01ff_8001_7f80_ff01, 64'hff01_807f_7f80_ff7f, 1'b1, 1'b1);
        send(SUB, 2'd0, 64'hff01_8000_0102_7f80, 64'h00ff_7f01_0201_8000, 1'b1, 1'b1);
        send(ADD, 2'd3, 64'h1, '1, 1'b1, 1'b1);
        send(SUB, 2'd3, 64'h1, '0, 1'b1, 1'b1);

        test_name = "min_max";  // sign bits differ in every lane
        for (int s = 0; s < 4; s++)
            for (int k = 0; k < 4; k++)
                send(alu_op_e'(MINU + k), sew_t'(s), 64'h7f80_8000_ff01_00fe,
                     64'h8001_7fff_0080_ff7f, 1'b1, 1'b1);

        test_name = "vid_group";
        for (int s = 0; s < 4; s++)
            for (int b = 0; b < 3; b++)
                send(VID, sew_t'(s), '0, '0, b == 0, b == 2);

        test_name = "redsum";
        for (int s = 0; s < 4; s++) begin
            for (int b = 0; b < 3; b++)
                send(REDSUM, sew_t'(s), rand_vec(), rand_vec(), b == 0, b == 2);
            send(REDSUM, sew_t'(s), rand_vec(), rand_vec(), 1'b1, 1'b1);
        end

        test_name = "mixed";
        for (int n = 0; n < 40; n++)
            send(alu_op_e'(4'({$random(seed)} % 12)), sew_t'($random(seed)), rand_vec(),
                 rand_vec(), 1'($random(seed)), 1'($random(seed)));

        req_valid <= 1'b0;
        repeat (4) @(posedge clk);
        if (exp_q.size() != 0) begin
            fail_run("expected responses never appeared");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== test/valu_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module valu_assert (
    input  logic       clk,
    input  logic       rst,
    input  logic       req_valid,
    input  logic [2:0] req_op_mnr,
    input  logic [5:0] req_func_id,
    input  logic       req_end,
    input  logic       resp_valid,
    input  logic       resp_end
);
    import valu_ops_pkg::*;

    int   fail_cnt = 0;
    logic red_mid;

    // reduction beat that does not close its group
    assign red_mid = req_valid && !req_end && (req_op_mnr == OPMVV)
                   && (req_func_id == FUNCT6_VREDSUM);

    // first beat after reset cannot reach the output for three edges
    quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !resp_valid [*3])
        else begin
            $error("resp_valid high during or right after reset");
            fail_cnt++;
        end

    no_resp_mid_group: assert property (@(posedge clk) disable iff (rst)
        red_mid |-> ##3 !resp_valid)
        else begin
            $error("response for a reduction beat without req_end");
            fail_cnt++;
        end

    end_follows_req: assert property (@(posedge clk) disable iff (rst)
        resp_end == $past(req_valid && req_end, 3))
        else begin
            $error("resp_end does not follow req_end of the beat");
            fail_cnt++;
        end

endmodule

bind valu_top valu_assert u_assert (
    .clk         (clk),
    .rst         (rst),
    .req_valid   (req_valid),
    .req_op_mnr  (req_op_mnr),
    .req_func_id (req_func_id),
    .req_end     (req_end),
    .resp_valid  (resp_valid),
    .resp_end    (resp_end)
);

`default_nettype wire

// ==== design/valu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module valu_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            req_valid,
    input  logic [2:0]      req_op_mnr,
    input  logic [5:0]      req_func_id,
    input  valu_pkg::sew_t  req_sew,
    input  valu_pkg::vec_t  req_data0,
    input  valu_pkg::vec_t  req_data1,
    input  valu_pkg::addr_t req_addr,
    input  valu_pkg::be_t   req_be,
    input  logic            req_start,
    input  logic            req_end,
    output logic            resp_valid,
    output logic            resp_start,
    output logic            resp_end,
    output valu_pkg::vec_t  resp_data,
    output valu_pkg::addr_t resp_addr,
    output valu_pkg::be_t   resp_be
);
    import valu_pkg::*;

    elem_idx_t beat_idx;
    s1_t       s1;
    vec_t      alu_data;
    side_t     alu_side;
    vec_t      red_data;
    side_t     red_side;
    logic      acc_clear;
    logic      acc_en;
    logic      emit;

    beat_counter u_beat_counter (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_start (req_start),
        .beat_idx  (beat_idx)
    );

    valu_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_op_mnr  (req_op_mnr),
        .req_func_id (req_func_id),
        .req_sew     (req_sew),
        .req_data0   (req_data0),
        .req_data1   (req_data1),
        .req_addr    (req_addr),
        .req_be      (req_be),
        .req_start   (req_start),
        .req_end     (req_end),
        .beat_idx    (beat_idx),
        .s1          (s1)
    );

    lane_alu u_lane_alu (
        .clk      (clk),
        .rst      (rst),
        .s1       (s1),
        .alu_data (alu_data),
        .alu_side (alu_side)
    );

    red_fsm u_red_fsm (
        .clk       (clk),
        .rst       (rst),
        .s1        (s1),
        .acc_clear (acc_clear),
        .acc_en    (acc_en),
        .emit      (emit)
    );

    red_accum u_red_accum (
        .clk       (clk),
        .rst       (rst),
        .s1        (s1),
        .acc_clear (acc_clear),
        .acc_en    (acc_en),
        .emit      (emit),
        .red_data  (red_data),
        .red_side  (red_side)
    );

    resp_stage u_resp_stage (
        .clk        (clk),
        .rst        (rst),
        .alu_data   (alu_data),
        .alu_side   (alu_side),
        .red_data   (red_data),
        .red_side   (red_side),
        .resp_valid (resp_valid),
        .resp_start (resp_start),
        .resp_end   (resp_end),
        .resp_data  (resp_data),
        .resp_addr  (resp_addr),
        .resp_be    (resp_be)
    );

endmodule

`default_nettype wire

// ==== design/resp_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module resp_stage (
    input  logic            clk,
    input  logic            rst,
    input  valu_pkg::vec_t  alu_data,
    input  valu_pkg::side_t alu_side,
    input  valu_pkg::vec_t  red_data,
    input  valu_pkg::side_t red_side,
    output logic            resp_valid,
    output logic            resp_start,
    output logic            resp_end,
    output valu_pkg::vec_t  resp_data,
    output valu_pkg::addr_t resp_addr,
    output valu_pkg::be_t   resp_be
);

    // units never respond in the same cycle, so a plain OR merges them
    always_ff @(posedge clk) begin
        resp_data <= (alu_side.valid ? alu_data : '0)
                   | (red_side.valid ? red_data : '0);
        resp_addr <= (alu_side.valid ? alu_side.addr : '0)
                   | (red_side.valid ? red_side.addr : '0);
        resp_be   <= (alu_side.valid ? alu_side.be : '0)
                   | (red_side.valid ? red_side.be : '0);

        if (rst) begin
            resp_valid <= 1'b0;
            resp_start <= 1'b0;
            resp_end   <= 1'b0;
        end else begin
            resp_valid <= alu_side.valid | red_side.valid;
            resp_start <= alu_side.start | red_side.start;
            resp_end   <= alu_side.last | red_side.last;
        end
    end

endmodule

`default_nettype wire

// ==== design/red_accum.sv ====
`timescale 1ns/1ps
`default_nettype none

module red_accum (
    input  logic            clk,
    input  logic            rst,
    input  valu_pkg::s1_t   s1,
    input  logic            acc_clear,
    input  logic            acc_en,
    input  logic            emit,
    output valu_pkg::vec_t  red_data,
    output valu_pkg::side_t red_side
);
    import valu_pkg::*;

    vec_t beat_sum [4];     // sum of data1 elements per sew
    vec_t sew_mask;
    vec_t seed;
    vec_t acc_q;
    vec_t acc_nxt;

    for (genvar j = 0; j < 4; j++) begin : g_sum
        localparam int EW = 8 << j;

        vec_t part;

        always_comb begin
            part = '0;
            for (int i = 0; i < DATA_W / EW; i++)
                part = part + vec_t'(s1.data1[i*EW +: EW]);
        end

        assign beat_sum[j] = part;
    end

    always_comb begin
        case (s1.sew)
            2'd0:    sew_mask = 64'h0000_0000_0000_00ff;
            2'd1:    sew_mask = 64'h0000_0000_0000_ffff;
            2'd2:    sew_mask = 64'h0000_0000_ffff_ffff;
            default: sew_mask = '1;
        endcase
    end

    assign seed    = s1.data0 & sew_mask;   // element 0 of data0
    assign acc_nxt = (acc_clear ? seed : acc_q) + beat_sum[s1.sew];

    always_ff @(posedge clk) begin
        if (acc_en)
            acc_q <= acc_nxt;

        if (emit) begin
            red_data <= acc_nxt & sew_mask; // result in element 0 only
            red_side <= s1.side;
        end else begin
            red_side.valid <= 1'b0;
            red_side.start <= 1'b0;
            red_side.last  <= 1'b0;
        end

        if (rst) begin
            red_side.valid <= 1'b0;
            red_side.start <= 1'b0;
            red_side.last  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== design/red_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module red_fsm (
    input  logic          clk,
    input  logic          rst,
    input  valu_pkg::s1_t s1,
    output logic          acc_clear,
    output logic          acc_en,
    output logic          emit
);
    import valu_ops_pkg::*;

    red_state_e state;
    red_state_e state_nxt;

    always_comb begin
        acc_clear = s1.red_beat & s1.side.start;
        // stray beats outside a group are dropped
        acc_en    = s1.red_beat & (s1.side.start | (state == RED_ACCUM));
        emit      = acc_en & s1.side.last;

        state_nxt = state;
        if (emit)
            state_nxt = RED_IDLE;
        else if (acc_clear)
            state_nxt = RED_ACCUM;
    end

    always_ff @(posedge clk) begin
        if (rst)
            state <= RED_IDLE;
        else
            state <= state_nxt;
    end

endmodule

`default_nettype wire

// ==== design/lane_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_alu (
    input  logic            clk,
    input  logic            rst,
    input  valu_pkg::s1_t   s1,
    output valu_pkg::vec_t  alu_data,
    output valu_pkg::side_t alu_side
);
    import valu_pkg::*;
    import valu_ops_pkg::*;

    vec_t res_sew [4];      // full-lane result per element width
    vec_t res;
    logic op_valid;

    for (genvar j = 0; j < 4; j++) begin : g_sew
        localparam int EW = 8 << j;

        for (genvar i = 0; i < DATA_W / EW; i++) begin : g_elem
            logic [EW-1:0]     a;
            logic [EW-1:0]     b;
            logic [EW-1:0]     r;
            logic [DATA_W-1:0] idx;
            logic              lt_u;
            logic              lt_s;

            assign a    = s1.data1[i*EW +: EW];
            assign b    = s1.data0[i*EW +: EW];
            assign idx  = DATA_W'(s1.elem_idx) + DATA_W'(i);
            assign lt_u = a < b;
            assign lt_s = $signed(a) < $signed(b);

            // data1 op data0, wraps inside the element
            always_comb begin
                case (s1.op)
                    ADD:     r = a + b;
                    SUB:     r = a - b;
                    MINU:    r = lt_u ? a : b;
                    MIN:     r = lt_s ? a : b;
                    MAXU:    r = lt_u ? b : a;
                    MAX:     r = lt_s ? b : a;
                    AND:     r = a & b;
                    OR:      r = a | b;
                    XOR:     r = a ^ b;
                    VID:     r = idx[EW-1:0];  // truncated to sew
                    default: r = '0;
                endcase
            end

            assign res_sew[j][i*EW +: EW] = r;
        end
    end

    assign res      = res_sew[s1.sew];
    assign op_valid = s1.side.valid && (s1.op != NONE) && (s1.op != REDSUM);

    always_ff @(posedge clk) begin
        alu_data       <= res;
        alu_side       <= s1.side;
        alu_side.valid <= op_valid;
        if (rst) begin
            alu_side.valid <= 1'b0;
            alu_side.start <= 1'b0;
            alu_side.last  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== design/valu_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module valu_decode (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    input  logic [2:0]          req_op_mnr,
    input  logic [5:0]          req_func_id,
    input  valu_pkg::sew_t      req_sew,
    input  valu_pkg::vec_t      req_data0,
    input  valu_pkg::vec_t      req_data1,
    input  valu_pkg::addr_t     req_addr,
    input  valu_pkg::be_t       req_be,
    input  logic                req_start,
    input  logic                req_end,
    input  valu_pkg::elem_idx_t beat_idx,
    output valu_pkg::s1_t       s1
);
    import valu_pkg::*;
    import valu_ops_pkg::*;

    alu_op_e op;
    s1_t     s1_d;

    always_comb begin
        op = NONE;
        case (req_op_mnr)
            OPIVV: begin
                case (req_func_id)
                    FUNCT6_VADD:  op = ADD;
                    FUNCT6_VSUB:  op = SUB;
                    FUNCT6_VMINU: op = MINU;
                    FUNCT6_VMIN:  op = MIN;
                    FUNCT6_VMAXU: op = MAXU;
                    FUNCT6_VMAX:  op = MAX;
                    FUNCT6_VAND:  op = AND;
                    FUNCT6_VOR:   op = OR;
                    FUNCT6_VXOR:  op = XOR;
                    default:      op = NONE;
                endcase
            end
            OPMVV: begin
                case (req_func_id)
                    FUNCT6_VREDSUM: op = REDSUM;
                    FUNCT6_VID:     op = VID;
                    default:        op = NONE;
                endcase
            end
            default: op = NONE;
        endcase
    end

    always_comb begin
        s1_d.side.valid = req_valid;
        s1_d.side.start = req_valid & req_start;
        s1_d.side.last  = req_valid & req_end;
        s1_d.side.addr  = req_addr;
        s1_d.side.be    = req_be;
        s1_d.op         = req_valid ? op : NONE;
        s1_d.sew        = req_sew;
        s1_d.data0      = req_data0;
        s1_d.data1      = req_data1;
        s1_d.elem_idx   = beat_idx << (2'd3 - req_sew); // beat * elements per beat
        s1_d.red_beat   = req_valid && (op == REDSUM);
    end

    always_ff @(posedge clk) begin
        s1 <= s1_d;
        if (rst) begin
            s1.side.valid <= 1'b0;
            s1.side.start <= 1'b0;
            s1.side.last  <= 1'b0;
            s1.op         <= NONE;
            s1.red_beat   <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== design/beat_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module beat_counter (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    input  logic                req_start,
    output valu_pkg::elem_idx_t beat_idx
);
    import valu_pkg::*;

    elem_idx_t cnt_q;

    // a start beat is always beat zero of its group
    assign beat_idx = req_start ? '0 : cnt_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q <= '0;
        end else if (req_valid) begin
            if (req_start)
                cnt_q <= elem_idx_t'(1);
            else
                cnt_q <= cnt_q + elem_idx_t'(1);
        end
    end

endmodule

`default_nettype wire

// ==== design/valu_pkg.sv ====
`default_nettype none

package valu_pkg;

    localparam int DATA_W = 64;
    localparam int ADDR_W = 32;
    localparam int BE_W   = DATA_W / 8;
    localparam int IDX_W  = 11;

    typedef logic [DATA_W-1:0] vec_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [BE_W-1:0]   be_t;
    typedef logic [1:0]        sew_t;      // 0 = 8 bit ... 3 = 64 bit
    typedef logic [IDX_W-1:0]  elem_idx_t;

    // sidebands that ride along with a beat
    typedef struct packed {
        logic  valid;
        logic  start;
        logic  last;
        addr_t addr;
        be_t   be;
    } side_t;

    // registered decode output
    typedef struct packed {
        side_t                 side;
        valu_ops_pkg::alu_op_e op;
        sew_t                  sew;
        vec_t                  data0;
        vec_t                  data1;
        elem_idx_t             elem_idx;   // index of element 0 of this beat
        logic                  red_beat;
    } s1_t;

endpackage

`default_nettype wire

// ==== design/valu_ops_pkg.sv ====
`default_nettype none

package valu_ops_pkg;

    // funct6 field, RISC-V vector encoding
    localparam logic [5:0] FUNCT6_VADD    = 6'b000000;
    localparam logic [5:0] FUNCT6_VSUB    = 6'b000010;
    localparam logic [5:0] FUNCT6_VMINU   = 6'b000100;
    localparam logic [5:0] FUNCT6_VMIN    = 6'b000101;
    localparam logic [5:0] FUNCT6_VMAXU   = 6'b000110;
    localparam logic [5:0] FUNCT6_VMAX    = 6'b000111;
    localparam logic [5:0] FUNCT6_VAND    = 6'b001001;
    localparam logic [5:0] FUNCT6_VOR     = 6'b001010;
    localparam logic [5:0] FUNCT6_VXOR    = 6'b001011;
    localparam logic [5:0] FUNCT6_VID     = 6'b010100;
    localparam logic [5:0] FUNCT6_VREDSUM = 6'b000000; // under OPMVV

    localparam logic [2:0] OPIVV = 3'd0;
    localparam logic [2:0] OPMVV = 3'd2;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        MINU,
        MIN,
        MAXU,
        MAX,
        AND,
        OR,
        XOR,
        VID,
        REDSUM,
        NONE
    } alu_op_e;

    typedef enum logic {
        RED_IDLE,
        RED_ACCUM
    } red_state_e;

endpackage

`default_nettype wire
